// File: decode_top.f
+incdir+design
design/ncpu_pkg.sv
design/insn_queue.sv
design/id_dec.sv
design/id.sv
design/decode_top.sv
dv/tb_decode_top.sv

// File: run.sh
#!/bin/sh
# Compile the decode_top testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_decode_top -f decode_top.f -o sim_decode_top
./obj_dir/sim_decode_top | tee sim.log

if grep -q "^Regression passed$" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

// File: dv/tb_decode_top.sv
// Testbench for decode_top that acts as fetch and as rename
// A 24 row table and an LFSR driven random phase push instructions
// A queue model and a reference decoder predict every rn bundle
// Compiled from the file list and run by the Verilator script
`timescale 1ns/1ps
`include "ncpu_params.svh"

module tb_decode_top;
   import ncpu_pkg::*;

   localparam int N_ROWS    = 24;
   localparam int N_RAND    = 200;
   localparam int WD_CYCLES = (N_ROWS + N_RAND) * 40;
   localparam exc_e EX_N    = EXC_NONE;
   localparam exc_e EX_F    = EXC_IFETCH_FAULT;

   // ctl holds irq, stall and flush
   typedef struct packed {
      logic [1:0]  mask;
      logic [31:0] ins0;
      logic [31:0] ins1;
      exc_e        exc0;
      exc_e        exc1;
      logic [2:0]  ctl;
   } row_t;

   typedef struct packed {
      fu_e         fu;
      uop_e        uop;
      exc_e        exc;
      logic [31:0] imm;
      logic        we;
      logic [4:0]  rd;
      logic        re1;
      logic [4:0]  rs1;
      logic        re2;
      logic [4:0]  rs2;
   } dec_t;

   typedef struct {
      logic [31:0] ins;
      logic [31:0] pc;
      exc_e        exc;
      int          tag;
   } entry_t;

   logic                              clk;
   logic                              rst;
   logic                              flush;
   logic                              rn_stall_req;
   logic                              irq_async;
   logic [`IW-1:0]                    fetch_valid;
   logic [`IW-1:0][`INSN_DW-1:0]      fetch_ins;
   logic [`IW-1:0][`PC_W-1:0]         fetch_pc;
   exc_e [`IW-1:0]                    fetch_exc;
   logic                              fetch_stall;
   logic [`IW-1:0]                    rn_valid;
   fu_e  [`IW-1:0]                    rn_fu;
   uop_e [`IW-1:0]                    rn_uop;
   exc_e [`IW-1:0]                    rn_exc;
   logic [`IW-1:0][`PC_W-1:0]         rn_pc;
   logic [`IW-1:0][`DATA_W-1:0]       rn_imm;
   logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs1;
   logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs2;
   logic [`IW-1:0]                    rn_lrs1_re;
   logic [`IW-1:0]                    rn_lrs2_re;
   logic [`IW-1:0][`LRF_AW-1:0]       rn_lrd;
   logic [`IW-1:0]                    rn_lrd_we;
   logic [`P_ISSUE_WIDTH:0]           rn_push_size;

   row_t                    tbl [N_ROWS];
   entry_t                  mq [$];
   dec_t                    exp_dec [`IW];
   logic [31:0]             exp_pc [`IW];
   int                      exp_tag [`IW];
   logic [`IW-1:0]          exp_valid;
   logic [`P_ISSUE_WIDTH:0] exp_size;
   logic [31:0]             lfsr = 32'd94;
   int                      cur_tag = 0;
   int                      errors = 0;

   decode_top uut
   (
      .clk          (clk),
      .rst          (rst),
      .flush        (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async    (irq_async),
      .fetch_valid  (fetch_valid),
      .fetch_ins    (fetch_ins),
      .fetch_pc     (fetch_pc),
      .fetch_exc    (fetch_exc),
      .fetch_stall  (fetch_stall),
      .rn_valid     (rn_valid),
      .rn_fu        (rn_fu),
      .rn_uop       (rn_uop),
      .rn_exc       (rn_exc),
      .rn_pc        (rn_pc),
      .rn_imm       (rn_imm),
      .rn_lrs1      (rn_lrs1),
      .rn_lrs2      (rn_lrs2),
      .rn_lrs1_re   (rn_lrs1_re),
      .rn_lrs2_re   (rn_lrs2_re),
      .rn_lrd       (rn_lrd),
      .rn_lrd_we    (rn_lrd_we),
      .rn_push_size (rn_push_size)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      #(WD_CYCLES * 20);
      $display("Timeout after %0d cycles, the stimulus never completed", WD_CYCLES);
      $display("Regression failed");
      $finish;
   end

   function automatic logic [31:0] enc_r(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
      return {opc, rd, rs1, rs2, 11'h000};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [15:0] imm16);
      return {opc, rd, rs1, imm16};
   endfunction

   // Galois form with taps for x^32 + x^30 + x^26 + x^25 + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Decode rules written out per opcode
   function automatic dec_t ref_decode(input logic [31:0] ins, input exc_e fexc,
                                       input logic irq);
      dec_t       d;
      logic [5:0] opc;
      logic [2:0] use_rrw;
      logic       known;
      opc   = ins[`OPC_MSB:`OPC_LSB];
      known = 1'b1;
      d.fu  = FU_EPU;
      d.imm = {{16{ins[15]}}, ins[15:0]};
      d.rd  = ins[`RD_MSB:`RD_LSB];
      d.rs1 = ins[`RS1_MSB:`RS1_LSB];
      d.rs2 = ins[`RS2_MSB:`RS2_LSB];
      case (opc)
         `OPC_ADD, `OPC_ADDI, `OPC_AND: d.fu = FU_ALU;
         `OPC_LW, `OPC_SW:              d.fu = FU_LSU;
         `OPC_BEQ, `OPC_JAL:            d.fu = FU_BRU;
         `OPC_SYSCALL:                  d.fu = FU_EPU;
         default:                       known = 1'b0;
      endcase
      case (opc)
         `OPC_ADD, `OPC_ADDI: d.uop = UOP_ADD;
         `OPC_AND:            d.uop = UOP_AND;
         `OPC_LW:             d.uop = UOP_LOAD;
         `OPC_SW:             d.uop = UOP_STORE;
         `OPC_BEQ:            d.uop = UOP_BEQ;
         `OPC_JAL:            d.uop = UOP_JAL;
         `OPC_SYSCALL:        d.uop = UOP_SYSCALL;
         default:             d.uop = UOP_EXC;
      endcase
      // Bits are rs1 read, rs2 read and rd write
      case (opc)
         `OPC_ADD, `OPC_AND: use_rrw = 3'b111;
         `OPC_ADDI, `OPC_LW: use_rrw = 3'b101;
         `OPC_SW, `OPC_BEQ:  use_rrw = 3'b110;
         `OPC_JAL:           use_rrw = 3'b001;
         default:            use_rrw = 3'b000;
      endcase
      if (fexc == EXC_IFETCH_FAULT)
         d.exc = EXC_IFETCH_FAULT;
      else if (irq)
         d.exc = EXC_IRQ;
      else if (!known)
         d.exc = EXC_ILLEGAL;
      else
         d.exc = EXC_NONE;
      if (d.exc != EXC_NONE)
      begin
         d.fu    = FU_EPU;
         d.uop   = UOP_EXC;
         use_rrw = 3'b000;
      end
      d.re1 = use_rrw[2];
      d.re2 = use_rrw[1];
      d.we  = use_rrw[0] && (d.rd != 5'd0);
      return d;
   endfunction

   task automatic check_fu(input string name, input fu_e exp, input fu_e act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_uop(input string name, input uop_e exp, input uop_e act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_exc(input string name, input exc_e exp, input exc_e act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Runs at the falling edge where DUT outputs and driven inputs are settled
   task automatic compare_outputs();
      string nm;
      logic  full;
      full = (`QUEUE_DEPTH - mq.size()) < `IW;
      check_reg($sformatf("row %0d fetch_stall", cur_tag), 5'(full), 5'(fetch_stall));
      check_reg($sformatf("row %0d rn_push_size", cur_tag), 5'(exp_size), 5'(rn_push_size));
      if (rn_valid !== exp_valid)
      begin
         errors++;
         $display("At row %0d rn_valid is %b instead of %b, an instruction was lost or invented",
                  cur_tag, rn_valid, exp_valid);
      end
      for (int i = 0; i < `IW; i++)
      begin
         if (exp_valid[i] && rn_valid[i])
         begin
            nm = $sformatf("row %0d slot %0d", exp_tag[i], i);
            check_fu({nm, " fu"}, exp_dec[i].fu, rn_fu[i]);
            check_uop({nm, " uop"}, exp_dec[i].uop, rn_uop[i]);
            check_exc({nm, " exc"}, exp_dec[i].exc, rn_exc[i]);
            check_word({nm, " pc"}, exp_pc[i], rn_pc[i]);
            check_word({nm, " imm"}, exp_dec[i].imm, rn_imm[i]);
            check_reg({nm, " lrs1"}, exp_dec[i].rs1, rn_lrs1[i]);
            check_reg({nm, " lrs2"}, exp_dec[i].rs2, rn_lrs2[i]);
            check_reg({nm, " lrd"}, exp_dec[i].rd, rn_lrd[i]);
            check_reg({nm, " lrs1_re"}, 5'(exp_dec[i].re1), 5'(rn_lrs1_re[i]));
            check_reg({nm, " lrs2_re"}, 5'(exp_dec[i].re2), 5'(rn_lrs2_re[i]));
            check_reg({nm, " lrd_we"}, 5'(exp_dec[i].we), 5'(rn_lrd_we[i]));
         end
      end
   endtask

   // Effect of the coming rising edge on the queue model and the rn bundle
   task automatic model_edge();
      entry_t e;
      int     npop;
      logic   full;
      full = (`QUEUE_DEPTH - mq.size()) < `IW;
      if (flush)
      begin
         mq.delete();
         exp_valid = '0;
         exp_size  = '0;
      end
      else
      begin
         if (!rn_stall_req)
         begin
            npop      = (mq.size() < `IW) ? mq.size() : `IW;
            exp_valid = '0;
            for (int i = 0; i < npop; i++)
            begin
               e            = mq.pop_front();
               exp_dec[i]   = ref_decode(e.ins, e.exc, (i == 0) && irq_async);
               exp_pc[i]    = e.pc;
               exp_tag[i]   = e.tag;
               exp_valid[i] = 1'b1;
            end
            exp_size = npop[`P_ISSUE_WIDTH:0];
         end
         for (int i = 0; i < `IW; i++)
         begin
            if (!full && fetch_valid[i])
               mq.push_back('{fetch_ins[i], fetch_pc[i], fetch_exc[i], cur_tag});
         end
      end
   endtask

   always @(negedge clk)
   begin
      if (rst)
      begin
         mq.delete();
         exp_valid = '0;
         exp_size  = '0;
      end
      else
      begin
         compare_outputs();
         model_edge();
      end
   end

   // A row stays on the inputs until the queue accepts it
   // Rename stall drops while the row waits for room
   task automatic drive_row(input row_t r, input int tag);
      @(posedge clk);
      cur_tag = tag;
      fetch_valid  <= r.mask;
      fetch_ins[0] <= r.ins0;
      fetch_ins[1] <= r.ins1;
      fetch_pc[0]  <= 32'h1000 + 32'(tag) * 8;
      fetch_pc[1]  <= 32'h1004 + 32'(tag) * 8;
      fetch_exc[0] <= r.exc0;
      fetch_exc[1] <= r.exc1;
      irq_async    <= r.ctl[2];
      rn_stall_req <= r.ctl[1];
      flush        <= r.ctl[0];
      @(negedge clk);
      while (fetch_stall && (r.mask != 2'b00) && !r.ctl[0])
      begin
         @(posedge clk);
         rn_stall_req <= 1'b0;
         @(negedge clk);
      end
   endtask

   task automatic random_row(output row_t r);
      logic [31:0] v;
      logic [31:0] w;
      take_bits(2, v);
      r.mask = (v[1:0] == 2'd0) ? 2'b00 : ((v[1:0] == 2'd1) ? 2'b01 : 2'b11);
      take_bits(4, v);
      take_bits(26, w);
      r.ins0 = {2'b00, v[3:0], w[25:0]};
      take_bits(4, v);
      take_bits(26, w);
      r.ins1 = {2'b00, v[3:0], w[25:0]};
      take_bits(3, v);
      r.exc0 = (v[2:0] == 3'b111) ? EXC_IFETCH_FAULT : EXC_NONE;
      take_bits(3, v);
      r.exc1 = (v[2:0] == 3'b111) ? EXC_IFETCH_FAULT : EXC_NONE;
      take_bits(3, v);
      r.ctl[2] = &v[2:0];
      take_bits(2, v);
      r.ctl[1] = &v[1:0];
      take_bits(5, v);
      r.ctl[0] = &v[4:0];
   endtask

   task automatic fill_table();
      // Opcode coverage in both slots then r0 writes and unknown opcodes
      tbl[0]  = '{2'b11, enc_r(`OPC_ADD, 3, 1, 2), enc_i(`OPC_ADDI, 4, 5, 16'hfffd),
                  EX_N, EX_N, 3'b000};
      tbl[1]  = '{2'b11, enc_r(`OPC_AND, 6, 7, 8), enc_i(`OPC_LW, 9, 10, 16'h0040),
                  EX_N, EX_N, 3'b000};
      tbl[2]  = '{2'b11, enc_i(`OPC_SW, 2, 11, 16'h8000), enc_i(`OPC_BEQ, 0, 13, 16'h7fff),
                  EX_N, EX_N, 3'b000};
      tbl[3]  = '{2'b11, enc_i(`OPC_JAL, 31, 0, 16'h1234), enc_i(`OPC_SYSCALL, 1, 2, 16'h3),
                  EX_N, EX_N, 3'b000};
      tbl[4]  = '{2'b01, enc_r(`OPC_ADD, 0, 1, 2), enc_r(`OPC_ADD, 5, 5, 5), EX_N, EX_N, 3'b000};
      tbl[5]  = '{2'b11, enc_i(`OPC_JAL, 0, 0, 16'hff00), enc_i(`OPC_LW, 0, 3, 16'h4),
                  EX_N, EX_N, 3'b000};
      tbl[6]  = '{2'b11, enc_r(6'd9, 1, 2, 3), enc_i(6'd63, 4, 5, 16'h0), EX_N, EX_N, 3'b000};
      // Fetch faults and interrupts
      tbl[7]  = '{2'b11, enc_r(`OPC_ADD, 1, 2, 3), enc_i(`OPC_ADDI, 2, 3, 16'h1),
                  EX_F, EX_F, 3'b100};
      tbl[8]  = '{2'b11, enc_r(`OPC_ADD, 7, 8, 9), enc_r(`OPC_AND, 10, 11, 12),
                  EX_N, EX_N, 3'b100};
      tbl[9]  = '{2'b11, enc_i(6'd20, 1, 1, 16'h0), enc_i(6'd21, 2, 2, 16'h0), EX_N, EX_N, 3'b100};
      tbl[10] = '{2'b00, 32'h0, 32'h0, EX_N, EX_N, 3'b100};
      // Rename stall until the queue fills
      tbl[11] = '{2'b11, enc_i(`OPC_LW, 1, 2, 16'h8), enc_i(`OPC_SW, 3, 4, 16'h10),
                  EX_N, EX_N, 3'b010};
      tbl[12] = '{2'b11, enc_r(`OPC_ADD, 5, 6, 7), enc_i(`OPC_ADDI, 8, 9, 16'h20),
                  EX_N, EX_N, 3'b010};
      tbl[13] = '{2'b11, enc_i(`OPC_BEQ, 1, 1, 16'hfff0), enc_i(`OPC_JAL, 31, 0, 16'h40),
                  EX_N, EX_N, 3'b010};
      tbl[14] = '{2'b11, enc_r(`OPC_AND, 2, 3, 4), enc_i(`OPC_SYSCALL, 0, 0, 16'h0),
                  EX_N, EX_N, 3'b010};
      tbl[15] = '{2'b01, enc_i(`OPC_ADDI, 7, 7, 16'h7), 32'h0, EX_N, EX_N, 3'b010};
      tbl[16] = '{2'b00, 32'h0, 32'h0, EX_N, EX_N, 3'b000};
      // Flush with a push in the same cycle and then with stalled contents
      tbl[17] = '{2'b11, enc_r(`OPC_ADD, 9, 9, 9), enc_r(`OPC_AND, 8, 8, 8), EX_N, EX_N, 3'b001};
      tbl[18] = '{2'b11, enc_i(`OPC_LW, 4, 4, 16'h4), enc_i(`OPC_SW, 4, 4, 16'h4),
                  EX_N, EX_N, 3'b010};
      tbl[19] = '{2'b00, 32'h0, 32'h0, EX_N, EX_N, 3'b001};
      tbl[20] = '{2'b11, enc_r(`OPC_ADD, 1, 2, 3), enc_i(`OPC_ADDI, 1, 2, 16'h5),
                  EX_N, EX_F, 3'b000};
      tbl[21] = '{2'b01, enc_i(`OPC_BEQ, 0, 6, 16'h0008), 32'h0, EX_N, EX_N, 3'b000};
      tbl[22] = '{2'b11, enc_r(`OPC_ADD, 3, 3, 3), enc_i(`OPC_LW, 5, 6, 16'h0),
                  EX_N, EX_F, 3'b100};
      tbl[23] = '{2'b00, 32'h0, 32'h0, EX_N, EX_N, 3'b000};
   endtask

   initial
   begin
      row_t r;
      rst          = 1'b1;
      flush        = 1'b0;
      rn_stall_req = 1'b0;
      irq_async    = 1'b0;
      fetch_valid  = '0;
      fetch_ins    = '0;
      fetch_pc     = '0;
      fetch_exc    = {EXC_NONE, EXC_NONE};
      fill_table();
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < N_ROWS; i++)
         drive_row(tbl[i], i);
      for (int i = 0; i < N_RAND; i++)
      begin
         random_row(r);
         drive_row(r, N_ROWS + i);
      end
      r = '{2'b00, 32'h0, 32'h0, EX_N, EX_N, 3'b000};
      drive_row(r, N_ROWS + N_RAND);
      while ((mq.size() != 0) || (exp_valid != '0))
         @(posedge clk);
      @(negedge clk);
      if ((rn_valid !== '0) || (fetch_stall !== 1'b0))
      begin
         errors++;
         $display("Queue did not drain, rn_valid %b fetch_stall %b", rn_valid, fetch_stall);
      end
      $display("Finished %0d rows with %0d errors", N_ROWS + N_RAND, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: design/decode_top.sv
// Top level of the decode front end
// Fetch pushes into the instruction queue, decode pops and drives rename
`timescale 1ns/1ps
`include "ncpu_params.svh"

module decode_top
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              flush,
   input  logic                              rn_stall_req,
   input  logic                              irq_async,
   input  logic [`IW-1:0]                    fetch_valid,
   input  logic [`IW-1:0][`INSN_DW-1:0]      fetch_ins,
   input  logic [`IW-1:0][`PC_W-1:0]         fetch_pc,
   input  ncpu_pkg::exc_e [`IW-1:0]          fetch_exc,
   output logic                              fetch_stall,
   output logic [`IW-1:0]                    rn_valid,
   output ncpu_pkg::fu_e [`IW-1:0]           rn_fu,
   output ncpu_pkg::uop_e [`IW-1:0]          rn_uop,
   output ncpu_pkg::exc_e [`IW-1:0]          rn_exc,
   output logic [`IW-1:0][`PC_W-1:0]         rn_pc,
   output logic [`IW-1:0][`DATA_W-1:0]       rn_imm,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs1,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs2,
   output logic [`IW-1:0]                    rn_lrs1_re,
   output logic [`IW-1:0]                    rn_lrs2_re,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrd,
   output logic [`IW-1:0]                    rn_lrd_we,
   output logic [`P_ISSUE_WIDTH:0]           rn_push_size
);
   import ncpu_pkg::*;

   // Queue head towards decode
   logic [`IW-1:0]               id_valid;
   logic [`IW-1:0][`INSN_DW-1:0] id_ins;
   logic [`IW-1:0][`PC_W-1:0]    id_pc;
   exc_e [`IW-1:0]               id_exc;
   logic [`P_ISSUE_WIDTH:0]      id_pop_cnt;

   insn_queue u_queue
   (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .fetch_valid (fetch_valid),
      .fetch_ins   (fetch_ins),
      .fetch_pc    (fetch_pc),
      .fetch_exc   (fetch_exc),
      .fetch_stall (fetch_stall),
      .id_valid    (id_valid),
      .id_ins      (id_ins),
      .id_pc       (id_pc),
      .id_exc      (id_exc),
      .id_pop_cnt  (id_pop_cnt)
   );

   id u_id
   (
      .clk          (clk),
      .rst          (rst),
      .flush        (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async    (irq_async),
      .id_valid     (id_valid),
      .id_ins       (id_ins),
      .id_pc        (id_pc),
      .id_exc       (id_exc),
      .id_pop_cnt   (id_pop_cnt),
      .rn_valid     (rn_valid),
      .rn_fu        (rn_fu),
      .rn_uop       (rn_uop),
      .rn_exc       (rn_exc),
      .rn_pc        (rn_pc),
      .rn_imm       (rn_imm),
      .rn_lrs1      (rn_lrs1),
      .rn_lrs2      (rn_lrs2),
      .rn_lrs1_re   (rn_lrs1_re),
      .rn_lrs2_re   (rn_lrs2_re),
      .rn_lrd       (rn_lrd),
      .rn_lrd_we    (rn_lrd_we),
      .rn_push_size (rn_push_size)
   );

endmodule

// File: design/id.sv
// Decode stage, one decoder per slot and the registers towards rename
// Pops every valid slot unless rename stalls; registers hold under stall
`timescale 1ns/1ps
`include "ncpu_params.svh"

module id
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              flush,
   input  logic                              rn_stall_req,
   input  logic                              irq_async,
   input  logic [`IW-1:0]                    id_valid,
   input  logic [`IW-1:0][`INSN_DW-1:0]      id_ins,
   input  logic [`IW-1:0][`PC_W-1:0]         id_pc,
   input  ncpu_pkg::exc_e [`IW-1:0]          id_exc,
   output logic [`P_ISSUE_WIDTH:0]           id_pop_cnt,
   output logic [`IW-1:0]                    rn_valid,
   output ncpu_pkg::fu_e [`IW-1:0]           rn_fu,
   output ncpu_pkg::uop_e [`IW-1:0]          rn_uop,
   output ncpu_pkg::exc_e [`IW-1:0]          rn_exc,
   output logic [`IW-1:0][`PC_W-1:0]         rn_pc,
   output logic [`IW-1:0][`DATA_W-1:0]       rn_imm,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs1,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrs2,
   output logic [`IW-1:0]                    rn_lrs1_re,
   output logic [`IW-1:0]                    rn_lrs2_re,
   output logic [`IW-1:0][`LRF_AW-1:0]       rn_lrd,
   output logic [`IW-1:0]                    rn_lrd_we,
   output logic [`P_ISSUE_WIDTH:0]           rn_push_size
);
   import ncpu_pkg::*;

   localparam int CNT_W = `P_ISSUE_WIDTH + 1;

   logic [`IW-1:0]               slot_irq;
   logic [CNT_W-1:0]             valid_cnt;
   fu_e  [`IW-1:0]               dec_fu;
   uop_e [`IW-1:0]               dec_uop;
   exc_e [`IW-1:0]               dec_exc;
   logic [`IW-1:0][`DATA_W-1:0]  dec_imm;
   logic [`IW-1:0]               dec_we;
   logic [`IW-1:0][`LRF_AW-1:0]  dec_waddr;
   logic [`IW-1:0]               dec_re1;
   logic [`IW-1:0][`LRF_AW-1:0]  dec_rs1;
   logic [`IW-1:0]               dec_re2;
   logic [`IW-1:0][`LRF_AW-1:0]  dec_rs2;

   // Interrupt attaches to the oldest slot only
   assign slot_irq = {{(`IW-1){1'b0}}, irq_async};

   genvar g;
   generate
      for (g = 0; g < `IW; g++)
      begin : gen_dec
         id_dec u_dec
         (
            .id_valid    (id_valid[g]),
            .id_ins      (id_ins[g]),
            .id_exc      (id_exc[g]),
            .irq_async   (slot_irq[g]),
            .fu          (dec_fu[g]),
            .uop         (dec_uop[g]),
            .exc         (dec_exc[g]),
            .imm         (dec_imm[g]),
            .rf_we       (dec_we[g]),
            .rf_waddr    (dec_waddr[g]),
            .rf_rs1_re   (dec_re1[g]),
            .rf_rs1_addr (dec_rs1[g]),
            .rf_rs2_re   (dec_re2[g]),
            .rf_rs2_addr (dec_rs2[g])
         );
      end
   endgenerate

   always_comb
   begin
      valid_cnt = '0;
      for (int i = 0; i < `IW; i++)
      begin
         valid_cnt = valid_cnt + CNT_W'(id_valid[i]);
      end
   end

   assign id_pop_cnt = rn_stall_req ? '0 : valid_cnt;

   // Bundle valid and size, flush wins over stall
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         rn_valid     <= '0;
         rn_push_size <= '0;
      end
      else if (!rn_stall_req)
      begin
         rn_valid     <= id_valid;
         rn_push_size <= id_pop_cnt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rn_stall_req)
      begin
         rn_fu      <= dec_fu;
         rn_uop     <= dec_uop;
         rn_exc     <= dec_exc;
         rn_pc      <= id_pc;
         rn_imm     <= dec_imm;
         rn_lrs1    <= dec_rs1;
         rn_lrs2    <= dec_rs2;
         rn_lrs1_re <= dec_re1;
         rn_lrs2_re <= dec_re2;
         rn_lrd     <= dec_waddr;
         rn_lrd_we  <= dec_we;
      end
   end

endmodule

// File: design/id_dec.sv
// Combinational decoder for one decode slot
// Produces unit class, micro-op, immediate, register fields and the exception tag
// irq_async arrives already masked for slots other than 0
`timescale 1ns/1ps
`include "ncpu_params.svh"

module id_dec
(
   input  logic                    id_valid,
   input  logic [`INSN_DW-1:0]     id_ins,
   input  ncpu_pkg::exc_e          id_exc,
   input  logic                    irq_async,
   output ncpu_pkg::fu_e           fu,
   output ncpu_pkg::uop_e          uop,
   output ncpu_pkg::exc_e          exc,
   output logic [`DATA_W-1:0]      imm,
   output logic                    rf_we,
   output logic [`LRF_AW-1:0]      rf_waddr,
   output logic                    rf_rs1_re,
   output logic [`LRF_AW-1:0]      rf_rs1_addr,
   output logic                    rf_rs2_re,
   output logic [`LRF_AW-1:0]      rf_rs2_addr
);
   import ncpu_pkg::*;

   localparam int IMM16_W = `IMM_MSB - `IMM_LSB + 1;

   logic [`OPC_W-1:0]  opc;
   logic [IMM16_W-1:0] imm16;
   logic               known;
   logic               we_op;
   logic               re1_op;
   logic               re2_op;
   logic               has_exc;
   fu_e                fu_op;
   uop_e               uop_op;
   exc_e               exc_tag;

   assign opc         = id_ins[`OPC_MSB:`OPC_LSB];
   assign imm16       = id_ins[`IMM_MSB:`IMM_LSB];
   assign rf_waddr    = id_ins[`RD_MSB:`RD_LSB];
   assign rf_rs1_addr = id_ins[`RS1_MSB:`RS1_LSB];
   assign rf_rs2_addr = id_ins[`RS2_MSB:`RS2_LSB];
   assign imm         = {{(`DATA_W-IMM16_W){imm16[IMM16_W-1]}}, imm16};

   // Opcode to class, micro-op and register usage
   always_comb
   begin
      known  = 1'b1;
      we_op  = 1'b0;
      re1_op = 1'b0;
      re2_op = 1'b0;
      fu_op  = FU_EPU;
      uop_op = UOP_EXC;
      case (opc)
         `OPC_ADD:     begin fu_op = FU_ALU; uop_op = UOP_ADD;   re1_op = 1'b1;
                             re2_op = 1'b1;  we_op = 1'b1; end
         `OPC_ADDI:    begin fu_op = FU_ALU; uop_op = UOP_ADD;   re1_op = 1'b1;
                             we_op = 1'b1; end
         `OPC_AND:     begin fu_op = FU_ALU; uop_op = UOP_AND;   re1_op = 1'b1;
                             re2_op = 1'b1;  we_op = 1'b1; end
         `OPC_LW:      begin fu_op = FU_LSU; uop_op = UOP_LOAD;  re1_op = 1'b1;
                             we_op = 1'b1; end
         `OPC_SW:      begin fu_op = FU_LSU; uop_op = UOP_STORE; re1_op = 1'b1;
                             re2_op = 1'b1; end
         `OPC_BEQ:     begin fu_op = FU_BRU; uop_op = UOP_BEQ;   re1_op = 1'b1;
                             re2_op = 1'b1; end
         `OPC_JAL:     begin fu_op = FU_BRU; uop_op = UOP_JAL;   we_op = 1'b1; end
         `OPC_SYSCALL: begin fu_op = FU_EPU; uop_op = UOP_SYSCALL; end
         default:      known = 1'b0;
      endcase
   end

   // First match wins: fetch fault, then IRQ, then illegal opcode
   always_comb
   begin
      if (id_exc == EXC_IFETCH_FAULT)
         exc_tag = EXC_IFETCH_FAULT;
      else if (id_valid && irq_async)
         exc_tag = EXC_IRQ;
      else if (!known)
         exc_tag = EXC_ILLEGAL;
      else
         exc_tag = EXC_NONE;
   end

   assign has_exc = (exc_tag != EXC_NONE);
   assign exc     = exc_tag;
   assign fu      = has_exc ? FU_EPU : fu_op;
   assign uop     = has_exc ? UOP_EXC : uop_op;

   // r0 is never written
   assign rf_we     = id_valid & ~has_exc & we_op & (rf_waddr != '0);
   assign rf_rs1_re = id_valid & ~has_exc & re1_op;
   assign rf_rs2_re = id_valid & ~has_exc & re2_op;

endmodule

// File: design/insn_queue.sv
// Instruction queue between fetch and decode
// Takes up to IW contiguous pushes per cycle and shows the IW oldest entries
// Decode retires id_pop_cnt entries at the same edge; flush empties it
`timescale 1ns/1ps
`include "ncpu_params.svh"

module insn_queue
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                flush,
   input  logic [`IW-1:0]                      fetch_valid,
   input  logic [`IW-1:0][`INSN_DW-1:0]        fetch_ins,
   input  logic [`IW-1:0][`PC_W-1:0]           fetch_pc,
   input  ncpu_pkg::exc_e [`IW-1:0]            fetch_exc,
   output logic                                fetch_stall,
   output logic [`IW-1:0]                      id_valid,
   output logic [`IW-1:0][`INSN_DW-1:0]        id_ins,
   output logic [`IW-1:0][`PC_W-1:0]           id_pc,
   output ncpu_pkg::exc_e [`IW-1:0]            id_exc,
   input  logic [`P_ISSUE_WIDTH:0]             id_pop_cnt
);
   import ncpu_pkg::*;

   localparam int DEPTH = `QUEUE_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = AW + 1;

   logic [`INSN_DW-1:0] ins_mem [DEPTH];
   logic [`PC_W-1:0]    pc_mem  [DEPTH];
   exc_e                exc_mem [DEPTH];

   logic [AW-1:0] head;
   logic [AW-1:0] tail;
   logic [CW-1:0] count;
   logic [CW-1:0] free_cnt;
   logic [CW-1:0] push_cnt;
   logic          push_ok;

   assign free_cnt    = CW'(DEPTH) - count;
   assign fetch_stall = (free_cnt < CW'(`IW));
   assign push_ok     = ~fetch_stall & ~flush;

   // Fetch slots are contiguous from slot 0
   always_comb
   begin
      push_cnt = '0;
      for (int i = 0; i < `IW; i++)
      begin
         push_cnt = push_cnt + CW'(fetch_valid[i]);
      end
   end

   // Slot i of a push lands at tail + i
   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         for (int i = 0; i < `IW; i++)
         begin
            if (fetch_valid[i])
            begin
               ins_mem[tail + AW'(i)] <= fetch_ins[i];
               pc_mem[tail + AW'(i)]  <= fetch_pc[i];
               exc_mem[tail + AW'(i)] <= fetch_exc[i];
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         head  <= head + AW'(id_pop_cnt);
         tail  <= tail + (push_ok ? AW'(push_cnt) : '0);
         count <= count + (push_ok ? push_cnt : '0) - CW'(id_pop_cnt);
      end
   end

   // Oldest entries towards decode, valid only where occupied
   genvar g;
   generate
      for (g = 0; g < `IW; g++)
      begin : gen_rd
         assign id_valid[g] = (count > CW'(g));
         assign id_ins[g]   = ins_mem[head + AW'(g)];
         assign id_pc[g]    = pc_mem[head + AW'(g)];
         assign id_exc[g]   = exc_mem[head + AW'(g)];
      end
   endgenerate

endmodule

// File: design/ncpu_pkg.sv
// Enumerations shared by the decode RTL and its testbench
// Import with ncpu_pkg::* where the literals are needed

package ncpu_pkg;

   // Execution unit that receives the micro-op
   typedef enum logic [1:0] {
      FU_ALU = 2'd0,
      FU_LSU = 2'd1,
      FU_BRU = 2'd2,
      FU_EPU = 2'd3
   } fu_e;

   typedef enum logic [2:0] {
      UOP_ADD     = 3'd0,
      UOP_AND     = 3'd1,
      UOP_LOAD    = 3'd2,
      UOP_STORE   = 3'd3,
      UOP_BEQ     = 3'd4,
      UOP_JAL     = 3'd5,
      UOP_SYSCALL = 3'd6,
      UOP_EXC     = 3'd7
   } uop_e;

   // Fetch gives NONE or IFETCH_FAULT, decode may override
   typedef enum logic [1:0] {
      EXC_NONE         = 2'd0,
      EXC_IFETCH_FAULT = 2'd1,
      EXC_ILLEGAL      = 2'd2,
      EXC_IRQ          = 2'd3
   } exc_e;

endpackage

// File: design/ncpu_params.svh
// Size and encoding constants for the two-wide decode front end
// Included by every RTL file and by the testbench that builds instructions
`ifndef NCPU_PARAMS_SVH
`define NCPU_PARAMS_SVH

// log2 of decode width, so IW slots per cycle
`define P_ISSUE_WIDTH 1
`define IW            (1 << `P_ISSUE_WIDTH)
`define QUEUE_DEPTH   8
`define INSN_DW       32
`define PC_W          32
`define DATA_W        32
`define LRF_AW        5

// Instruction fields
`define OPC_W         6
`define OPC_MSB       31
`define OPC_LSB       26
`define RD_MSB        25
`define RD_LSB        21
`define RS1_MSB       20
`define RS1_LSB       16
`define RS2_MSB       15
`define RS2_LSB       11
`define IMM_MSB       15
`define IMM_LSB       0

// Major opcodes, anything else is illegal
`define OPC_ADD       6'd0
`define OPC_ADDI      6'd1
`define OPC_AND       6'd2
`define OPC_LW        6'd3
`define OPC_SW        6'd4
`define OPC_BEQ       6'd5
`define OPC_JAL       6'd6
`define OPC_SYSCALL   6'd7

`endif
